//--- verilog/prm2bits_pkg.sv
`default_nettype none

package prm2bits_pkg;

	//////////////////////////////
	// Vector types
	//////////////////////////////

	typedef logic [15:0] word16_t;
	typedef logic [31:0] word32_t;
	typedef logic [11:0] mem_addr_t;

	//////////////////////////////
	// Memory map
	//////////////////////////////

	// Serial area, 128-word aligned
	localparam mem_addr_t SERIAL_BASE = 12'h100;
	// Parameter area, 16-word aligned
	localparam mem_addr_t PRM_BASE = 12'h180;
	// Bit-count table in constant memory
	localparam mem_addr_t BITSNO_BASE = 12'h000;

	//////////////////////////////
	// Frame format
	//////////////////////////////

	localparam word16_t SYNC_WORD = 16'h6B21;
	localparam word16_t SERIAL_SIZE = 16'd80;
	localparam word16_t PRM_SIZE = 16'd11;
	localparam word16_t BIT_0 = 16'h007F;
	localparam word16_t BIT_1 = 16'h0081;

	// Packing controller
	typedef enum logic [2:0] {
		prm_idle,
		prm_write_sync,
		prm_write_size,
		prm_fetch,
		prm_launch,
		prm_wait_expand,
		prm_finish
	} prm_state_t;

	// Bit-expansion engine
	typedef enum logic [1:0] {
		i2b_idle,
		i2b_shift,
		i2b_finish
	} i2b_state_t;

endpackage

`default_nettype wire

//--- verilog/scratch_mem.sv
`timescale 1ns/100ps
`default_nettype none

module scratch_mem (
	input  logic                    clock,
	input  prm2bits_pkg::mem_addr_t eng_read_addr,
	input  prm2bits_pkg::mem_addr_t eng_write_addr,
	input  prm2bits_pkg::word32_t   eng_write_data,
	input  logic                    eng_write_en,
	output prm2bits_pkg::word32_t   eng_read_data,
	input  logic                    host_write_en,
	input  prm2bits_pkg::mem_addr_t host_addr,
	input  prm2bits_pkg::word32_t   host_write_data,
	output prm2bits_pkg::word32_t   host_read_data
);
	import prm2bits_pkg::*;

	word32_t mem [0:4095];

	//////////////////////////////
	// Write ports
	//////////////////////////////

	// Port A is assigned last so it wins a same-address collision
	always_ff @(posedge clock) begin
		if (host_write_en)
			mem[host_addr] <= host_write_data;
		if (eng_write_en)
			mem[eng_write_addr] <= eng_write_data;
	end

	//////////////////////////////
	// Registered reads
	//////////////////////////////

	always_ff @(posedge clock) begin
		eng_read_data <= mem[eng_read_addr];
	end

	always_ff @(posedge clock) begin
		host_read_data <= mem[host_addr];
	end

endmodule

`default_nettype wire

//--- verilog/bitsno_rom.sv
`timescale 1ns/100ps
`default_nettype none

module bitsno_rom (
	input  logic                    clock,
	input  prm2bits_pkg::mem_addr_t rom_read_addr,
	output prm2bits_pkg::word32_t   rom_data
);
	import prm2bits_pkg::*;

	word16_t bitsno;

	// Bits per parameter of an 8 kbit/s frame
	always_comb begin
		bitsno = 16'd0;
		if (rom_read_addr[11:4] == BITSNO_BASE[11:4]) begin
			case (rom_read_addr[3:0])
				4'd0: bitsno = 16'd8;
				4'd1: bitsno = 16'd10;
				4'd2: bitsno = 16'd8;
				4'd3: bitsno = 16'd1;
				4'd4: bitsno = 16'd13;
				4'd5: bitsno = 16'd4;
				4'd6: bitsno = 16'd7;
				4'd7: bitsno = 16'd5;
				4'd8: bitsno = 16'd13;
				4'd9: bitsno = 16'd4;
				4'd10: bitsno = 16'd7;
				default: bitsno = 16'd0;
			endcase
		end
	end

	// Zero-extended, one cycle of latency
	always_ff @(posedge clock) begin
		rom_data <= {16'd0, bitsno};
	end

endmodule

`default_nettype wire

//--- verilog/int2bin.sv
`timescale 1ns/100ps
`default_nettype none

module int2bin (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    i2b_start,
	input  prm2bits_pkg::word16_t   i2b_value,
	input  prm2bits_pkg::word16_t   i2b_bitsno,
	input  prm2bits_pkg::word16_t   i2b_pos,
	output logic                    i2b_done,
	output prm2bits_pkg::mem_addr_t i2b_write_addr,
	output prm2bits_pkg::word32_t   i2b_write_data,
	output logic                    i2b_write_en
);
	import prm2bits_pkg::*;

	i2b_state_t state;
	word16_t count_q;
	word16_t value_q;
	mem_addr_t ptr_q;
	mem_addr_t last_addr;

	// Word of the parameter's last bit in the stream
	assign last_addr = SERIAL_BASE + 12'd2 + i2b_pos[11:0] + i2b_bitsno[11:0] - 12'd1;

	//////////////////////////////
	// Control
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= i2b_idle;
			count_q <= '0;
		end else begin
			case (state)
				i2b_idle: begin
					if (i2b_start) begin
						count_q <= i2b_bitsno;
						// Nothing to expand, report at once
						if (i2b_bitsno == 16'd0)
							state <= i2b_finish;
						else
							state <= i2b_shift;
					end
				end
				i2b_shift: begin
					count_q <= count_q - 16'd1;
					if (count_q == 16'd1)
						state <= i2b_finish;
				end
				i2b_finish: begin
					state <= i2b_idle;
				end
				default: begin
					state <= i2b_idle;
				end
			endcase
		end
	end

	//////////////////////////////
	// Value and write pointer
	//////////////////////////////

	// LSB goes to the highest word, so the stream reads MSB first
	always_ff @(posedge clock) begin
		if (state == i2b_idle && i2b_start) begin
			value_q <= i2b_value;
			ptr_q <= last_addr;
		end else if (state == i2b_shift) begin
			value_q <= value_q >> 1;
			ptr_q <= ptr_q - 12'd1;
		end
	end

	assign i2b_write_en = (state == i2b_shift);
	assign i2b_write_addr = ptr_q;
	assign i2b_write_data = {16'd0, value_q[0] ? BIT_1 : BIT_0};
	assign i2b_done = (state == i2b_finish);

endmodule

`default_nettype wire

//--- verilog/prm2bits_ld8k.sv
`timescale 1ns/100ps
`default_nettype none

module prm2bits_ld8k (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    start,
	output logic                    done,
	output prm2bits_pkg::mem_addr_t eng_read_addr,
	output prm2bits_pkg::mem_addr_t eng_write_addr,
	output prm2bits_pkg::word32_t   eng_write_data,
	output logic                    eng_write_en,
	input  prm2bits_pkg::word32_t   eng_read_data,
	output prm2bits_pkg::mem_addr_t rom_read_addr,
	input  prm2bits_pkg::word32_t   rom_data,
	output logic                    i2b_start,
	output prm2bits_pkg::word16_t   i2b_value,
	output prm2bits_pkg::word16_t   i2b_bitsno,
	output prm2bits_pkg::word16_t   i2b_pos,
	input  logic                    i2b_done,
	input  prm2bits_pkg::mem_addr_t i2b_write_addr,
	input  prm2bits_pkg::word32_t   i2b_write_data,
	input  logic                    i2b_write_en
);
	import prm2bits_pkg::*;

	prm_state_t state;
	prm_state_t state_next;
	prm_state_t phase;
	word16_t prm_index;
	word16_t prm_index_next;
	word16_t bit_pos;
	word16_t bit_pos_next;
	word16_t bitsno_q;
	word16_t bitsno_next;

	// Start accepted in idle is the sync write itself
	always_comb begin
		if (state == prm_idle && start)
			phase = prm_write_sync;
		else
			phase = state;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= prm_idle;
			prm_index <= '0;
			bit_pos <= '0;
		end else begin
			state <= state_next;
			prm_index <= prm_index_next;
			bit_pos <= bit_pos_next;
		end
	end

	always_ff @(posedge clock) begin
		bitsno_q <= bitsno_next;
	end

	//////////////////////////////
	// Parameter fetch
	//////////////////////////////

	// Both reads follow the index, data is used in launch
	assign eng_read_addr = {PRM_BASE[11:4], prm_index[3:0]};
	assign rom_read_addr = {BITSNO_BASE[11:4], prm_index[3:0]};

	assign i2b_value = eng_read_data[15:0];
	assign i2b_bitsno = rom_data[15:0];
	assign i2b_pos = bit_pos;

	assign done = (state == prm_finish);

	//////////////////////////////
	// Sequencing
	//////////////////////////////

	always_comb begin
		state_next = state;
		prm_index_next = prm_index;
		bit_pos_next = bit_pos;
		bitsno_next = bitsno_q;
		eng_write_addr = '0;
		eng_write_data = '0;
		eng_write_en = 1'b0;
		i2b_start = 1'b0;

		case (phase)
			prm_idle: begin
				state_next = prm_idle;
			end
			prm_write_sync: begin
				eng_write_addr = SERIAL_BASE;
				eng_write_data = {16'd0, SYNC_WORD};
				eng_write_en = 1'b1;
				prm_index_next = '0;
				bit_pos_next = '0;
				state_next = prm_write_size;
			end
			prm_write_size: begin
				eng_write_addr = SERIAL_BASE + 12'd1;
				eng_write_data = {16'd0, SERIAL_SIZE};
				eng_write_en = 1'b1;
				state_next = prm_fetch;
			end
			prm_fetch: begin
				state_next = prm_launch;
			end
			prm_launch: begin
				i2b_start = 1'b1;
				bitsno_next = rom_data[15:0];
				state_next = prm_wait_expand;
			end
			prm_wait_expand: begin
				// Engine owns port A until it reports done
				eng_write_addr = i2b_write_addr;
				eng_write_data = i2b_write_data;
				eng_write_en = i2b_write_en;
				if (i2b_done) begin
					bit_pos_next = bit_pos + bitsno_q;
					prm_index_next = prm_index + 16'd1;
					if (prm_index == PRM_SIZE - 16'd1)
						state_next = prm_finish;
					else
						state_next = prm_fetch;
				end
			end
			prm_finish: begin
				state_next = prm_idle;
			end
			default: begin
				state_next = prm_idle;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/speech_bits_top.sv
`timescale 1ns/100ps
`default_nettype none

module speech_bits_top (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    start,
	output logic                    done,
	input  logic                    host_write_en,
	input  prm2bits_pkg::mem_addr_t host_addr,
	input  prm2bits_pkg::word32_t   host_write_data,
	output prm2bits_pkg::word32_t   host_read_data
);
	import prm2bits_pkg::*;

	// Scratch memory port A
	mem_addr_t eng_read_addr;
	mem_addr_t eng_write_addr;
	word32_t eng_write_data;
	logic eng_write_en;
	word32_t eng_read_data;

	mem_addr_t rom_read_addr;
	word32_t rom_data;

	// Controller to engine
	logic i2b_start;
	word16_t i2b_value;
	word16_t i2b_bitsno;
	word16_t i2b_pos;
	logic i2b_done;
	mem_addr_t i2b_write_addr;
	word32_t i2b_write_data;
	logic i2b_write_en;

	prm2bits_ld8k ctrl_inst (
		.clock(clock),
		.reset(reset),
		.start(start),
		.done(done),
		.eng_read_addr(eng_read_addr),
		.eng_write_addr(eng_write_addr),
		.eng_write_data(eng_write_data),
		.eng_write_en(eng_write_en),
		.eng_read_data(eng_read_data),
		.rom_read_addr(rom_read_addr),
		.rom_data(rom_data),
		.i2b_start(i2b_start),
		.i2b_value(i2b_value),
		.i2b_bitsno(i2b_bitsno),
		.i2b_pos(i2b_pos),
		.i2b_done(i2b_done),
		.i2b_write_addr(i2b_write_addr),
		.i2b_write_data(i2b_write_data),
		.i2b_write_en(i2b_write_en)
	);

	int2bin i2b_inst (
		.clock(clock),
		.reset(reset),
		.i2b_start(i2b_start),
		.i2b_value(i2b_value),
		.i2b_bitsno(i2b_bitsno),
		.i2b_pos(i2b_pos),
		.i2b_done(i2b_done),
		.i2b_write_addr(i2b_write_addr),
		.i2b_write_data(i2b_write_data),
		.i2b_write_en(i2b_write_en)
	);

	scratch_mem scratch_inst (
		.clock(clock),
		.eng_read_addr(eng_read_addr),
		.eng_write_addr(eng_write_addr),
		.eng_write_data(eng_write_data),
		.eng_write_en(eng_write_en),
		.eng_read_data(eng_read_data),
		.host_write_en(host_write_en),
		.host_addr(host_addr),
		.host_write_data(host_write_data),
		.host_read_data(host_read_data)
	);

	bitsno_rom rom_inst (
		.clock(clock),
		.rom_read_addr(rom_read_addr),
		.rom_data(rom_data)
	);

endmodule

`default_nettype wire

//--- sim/prm2bits_props.sv
`timescale 1ns/100ps
`default_nettype none

module prm2bits_props (
	input logic                       clock,
	input logic                       reset,
	input logic                       start,
	input logic                       done,
	input logic                       i2b_start,
	input logic                       eng_write_en,
	input prm2bits_pkg::prm_state_t   state
);
	import prm2bits_pkg::*;

	//////////////////////////////
	// Controller properties
	//////////////////////////////

	// Single-cycle done pulse
	done_one_cycle: assert property (@(posedge clock) disable iff (reset)
		done |=> !done)
		else $error("done stayed high for more than one cycle");

	// Engine only launched from the launch state
	start_in_launch: assert property (@(posedge clock) disable iff (reset)
		i2b_start |-> (state == prm_launch))
		else $error("i2b_start fired outside the launch state");

	// Idle and no start means port A stays quiet
	no_idle_write: assert property (@(posedge clock) disable iff (reset)
		(state == prm_idle && !start) |-> !eng_write_en)
		else $error("write on port A while idle without start");

endmodule

bind prm2bits_ld8k prm2bits_props props_inst (
	.clock(clock),
	.reset(reset),
	.start(start),
	.done(done),
	.i2b_start(i2b_start),
	.eng_write_en(eng_write_en),
	.state(state)
);

`default_nettype wire

//--- sim/tb_speech_bits.sv
`timescale 1ns/100ps
`default_nettype none

module tb_speech_bits;
	import prm2bits_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_FRAMES = 20;
	localparam int FRAME_CYCLES = 300;
	localparam int START_TO_DONE = 116;
	localparam int STREAM_WORDS = 82;
	localparam int NUM_PRMS = 11;
	localparam logic [31:0] RAND_SEED = 32'hfe74e19a;

	// Expected stream format
	localparam word32_t EXP_SYNC = 32'h0000_6B21;
	localparam word32_t EXP_SIZE = 32'd80;
	localparam word32_t EXP_ONE = 32'h0000_0081;
	localparam word32_t EXP_ZERO = 32'h0000_007F;
	localparam mem_addr_t SERIAL_AT = 12'h100;
	localparam mem_addr_t PRM_AT = 12'h180;

	logic clock;
	logic reset;
	logic start;
	logic done;
	logic host_write_en;
	mem_addr_t host_addr;
	word32_t host_write_data;
	word32_t host_read_data;

	word16_t prm_vals [0:NUM_PRMS-1];
	word32_t expected [0:STREAM_WORDS-1];
	word32_t readback [0:STREAM_WORDS-1];

	speech_bits_top speech_bits_inst (
		.clock(clock),
		.reset(reset),
		.start(start),
		.done(done),
		.host_write_en(host_write_en),
		.host_addr(host_addr),
		.host_write_data(host_write_data),
		.host_read_data(host_read_data)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	initial begin
		#(NUM_FRAMES * FRAME_CYCLES * CLK_PERIOD);
		$display("Watchdog expired before all frames were checked");
		$display("Done: errors found");
		$fatal(1, "Simulation time limit reached");
	end

	//////////////////////////////
	// Checks
	//////////////////////////////

	task automatic check_word(input string name, input word32_t actual, input word32_t want);
		if (actual !== want) begin
			$display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, actual, want);
			$display("Done: errors found");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	task automatic check_flag(input string name, input logic actual, input logic want);
		if (actual !== want) begin
			$display("[FAIL] %0t ns %s: got %b, expected %b", $time, name, actual, want);
			$display("Done: errors found");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	// G.729 bits per parameter
	function automatic int bitsno_of(input int idx);
		case (idx)
			0: return 8;
			1: return 10;
			2: return 8;
			3: return 1;
			4: return 13;
			5: return 4;
			6: return 7;
			7: return 5;
			8: return 13;
			9: return 4;
			10: return 7;
			default: return 0;
		endcase
	endfunction

	//////////////////////////////
	// Stimulus and model
	//////////////////////////////

	// Every edge also confirms done
	task automatic next_cycle(input logic want_done);
		@(posedge clock);
		check_flag("done", done, want_done);
	endtask

	task automatic load_params;
		for (int i = 0; i < NUM_PRMS; i++) begin
			prm_vals[i] = word16_t'($urandom);
			next_cycle(1'b0);
			host_write_en <= 1'b1;
			host_addr <= PRM_AT + mem_addr_t'(i);
			host_write_data <= {16'd0, prm_vals[i]};
		end
	endtask

	task automatic build_expected;
		int pos;
		expected[0] = EXP_SYNC;
		expected[1] = EXP_SIZE;
		pos = 2;
		for (int i = 0; i < NUM_PRMS; i++) begin
			for (int b = bitsno_of(i) - 1; b >= 0; b--) begin
				expected[pos] = prm_vals[i][b] ? EXP_ONE : EXP_ZERO;
				pos++;
			end
		end
	endtask

	// A stray start lands while the frame is busy
	task automatic run_frame;
		int stray_at;
		stray_at = 3 + ($urandom % 100);
		next_cycle(1'b0);
		host_write_en <= 1'b0;
		start <= 1'b1;
		for (int n = 1; n <= START_TO_DONE; n++) begin
			next_cycle(n == START_TO_DONE);
			start <= (n == stray_at);
		end
	endtask

	// Two cycles from address to sampled data
	task automatic read_block(input mem_addr_t base, input int count);
		for (int i = 0; i < count + 2; i++) begin
			next_cycle(1'b0);
			if (i >= 2)
				readback[i-2] = host_read_data;
			if (i < count)
				host_addr <= base + mem_addr_t'(i);
		end
	endtask

	initial begin
		int gap;
		void'($urandom(RAND_SEED));
		reset = 1'b1;
		start = 1'b0;
		host_write_en = 1'b0;
		host_addr = '0;
		host_write_data = '0;

		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		next_cycle(1'b0);

		for (int f = 0; f < NUM_FRAMES; f++) begin
			load_params();
			build_expected();
			run_frame();

			read_block(SERIAL_AT, STREAM_WORDS);
			for (int i = 0; i < STREAM_WORDS; i++)
				check_word($sformatf("serial[%0d]", i), readback[i], expected[i]);

			// Parameter area untouched by packing
			read_block(PRM_AT, NUM_PRMS);
			for (int i = 0; i < NUM_PRMS; i++)
				check_word($sformatf("prm[%0d]", i), readback[i], {16'd0, prm_vals[i]});

			gap = $urandom % 4;
			repeat (gap) next_cycle(1'b0);
		end

		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
verilog/prm2bits_pkg.sv
verilog/scratch_mem.sv
verilog/bitsno_rom.sv
verilog/int2bin.sv
verilog/prm2bits_ld8k.sv
verilog/speech_bits_top.sv
sim/prm2bits_props.sv
sim/tb_speech_bits.sv
